// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := sched_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
design/sched_pkg.sv
design/sched_regs.sv
design/credit_shaper.sv
design/gate_ctrl.sv
design/prio_select.sv
design/sched_top.sv
test/sched_props.sv
test/sched_tb.sv

// ==== design/credit_shaper.sv ====
`timescale 1ns/10ps

module credit_shaper #(
    parameter int NUM_QUEUES = sched_pkg::NUM_QUEUES
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_qav_en,
    input  sched_pkg::slope_t      i_idle_slope [NUM_QUEUES],
    input  sched_pkg::slope_t      i_send_slope [NUM_QUEUES],
    input  sched_pkg::credit_t     i_hi_thresh [NUM_QUEUES],
    input  sched_pkg::credit_t     i_lo_thresh [NUM_QUEUES],
    input  sched_pkg::queue_mask_t i_fifo_empty,
    input  sched_pkg::queue_mask_t i_tx_queue,    // held scheduler result
    input  logic                   i_tx_valid,
    input  logic                   i_tx_last,
    output sched_pkg::queue_mask_t o_eligible
);

    sched_pkg::credit_t     credit [NUM_QUEUES];
    sched_pkg::credit_t     credit_nxt [NUM_QUEUES];
    sched_pkg::queue_mask_t frame_q;   // queue owning the current frame
    sched_pkg::queue_mask_t sending;   // queue charged this cycle
    logic                   in_frame;  // past the first beat

    // credit minus send slope, floored at lo
    function automatic sched_pkg::credit_t sat_sub(sched_pkg::credit_t c, sched_pkg::slope_t s,
                                                   sched_pkg::credit_t lo);
        logic signed [17:0] d;
        d = c - $signed({10'd0, s});
        return (d < lo) ? lo : sched_pkg::credit_t'(d[15:0]);
    endfunction

    // credit plus idle slope, capped at hi
    function automatic sched_pkg::credit_t sat_add(sched_pkg::credit_t c, sched_pkg::slope_t s,
                                                   sched_pkg::credit_t hi);
        logic signed [17:0] d;
        d = c + $signed({10'd0, s});
        return (d > hi) ? hi : sched_pkg::credit_t'(d[15:0]);
    endfunction

    // frame tracking, last beat closes it
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            in_frame <= 1'b0;
        end else if (i_tx_valid) begin
            in_frame <= !i_tx_last;
        end
    end

    // latch owner on first beat so a new decision mid-frame does not move the charge
    always_ff @(posedge i_clk) begin
        if (i_tx_valid && !in_frame) begin
            frame_q <= i_tx_queue;
        end
    end

    assign sending = i_tx_valid ? (in_frame ? frame_q : i_tx_queue) : '0;

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (!i_qav_en) begin
                credit_nxt[q] = '0;                      // shaper off, park at zero
            end else if (sending[q]) begin
                credit_nxt[q] = sat_sub(credit[q], i_send_slope[q], i_lo_thresh[q]);
            end else if (!i_fifo_empty[q]) begin
                credit_nxt[q] = sat_add(credit[q], i_idle_slope[q], i_hi_thresh[q]);
            end else if (credit[q] > 0) begin
                credit_nxt[q] = '0;                      // no backlog, drop surplus
            end else begin
                credit_nxt[q] = credit[q];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                credit[q] <= '0;
            end
        end else begin
            credit <= credit_nxt;
        end
    end

    // eligible at zero or above, everything passes when disabled
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            o_eligible[q] = !i_qav_en || !credit[q][15];
        end
    end

endmodule

// ==== design/gate_ctrl.sv ====
`timescale 1ns/10ps

module gate_ctrl #(
    parameter int NUM_QUEUES = sched_pkg::NUM_QUEUES
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_qbv_en,
    input  sched_pkg::queue_mask_t i_gate_mask [sched_pkg::GCL_DEPTH],
    input  sched_pkg::interval_t   i_gate_interval [sched_pkg::GCL_DEPTH],
    input  sched_pkg::gcl_idx_t    i_list_last,   // last entry before wrap
    output sched_pkg::queue_mask_t o_gate_open
);

    typedef enum logic {
        GATE_IDLE,   // all gates open
        GATE_RUN     // walking the list
    } gate_state_t;

    gate_state_t          state;
    sched_pkg::gcl_idx_t  idx;       // active entry
    sched_pkg::gcl_idx_t  idx_nxt;
    sched_pkg::interval_t cnt;       // cycles left in entry, minus one

    // zero interval still holds the entry for one cycle
    function automatic sched_pkg::interval_t cnt_load(sched_pkg::interval_t ival);
        return (ival == '0) ? '0 : ival - 1'b1;
    endfunction

    assign idx_nxt = (idx == i_list_last) ? '0 : idx + 1'b1;  // wrap after last

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= GATE_IDLE;
            idx   <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                GATE_IDLE: begin
                    if (i_qbv_en) begin
                        state <= GATE_RUN;             // entry 0 live next cycle
                        idx   <= '0;
                        cnt   <= cnt_load(i_gate_interval[0]);
                    end
                end
                GATE_RUN: begin
                    if (!i_qbv_en) begin
                        state <= GATE_IDLE;
                        idx   <= '0;                   // rest at entry 0
                        cnt   <= '0;
                    end else if (cnt == '0) begin
                        idx <= idx_nxt;
                        cnt <= cnt_load(i_gate_interval[idx_nxt]);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= GATE_IDLE;
                end
            endcase
        end
    end

    // open mask straight from the active entry
    assign o_gate_open = (state == GATE_RUN) ? i_gate_mask[idx] : {NUM_QUEUES{1'b1}};

endmodule

// ==== design/prio_select.sv ====
`timescale 1ns/10ps

module prio_select #(
    parameter int NUM_QUEUES = sched_pkg::NUM_QUEUES
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_req,          // one-cycle request from mac
    input  sched_pkg::queue_mask_t i_fifo_empty,
    input  sched_pkg::queue_mask_t i_gate_open,
    input  sched_pkg::queue_mask_t i_eligible,
    output sched_pkg::queue_mask_t o_result,       // one-hot or zero
    output logic                   o_result_vld
);

    sched_pkg::queue_mask_t cand;   // non-empty, open and eligible
    sched_pkg::queue_mask_t pick;   // highest candidate, one-hot

    assign cand = ~i_fifo_empty & i_gate_open & i_eligible;

    // upward scan, last hit wins so the top queue takes it
    always_comb begin
        pick = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (cand[q]) begin
                pick    = '0;
                pick[q] = 1'b1;
            end
        end
    end

    // result lands one cycle after the request and holds
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_result     <= '0;
            o_result_vld <= 1'b0;
        end else begin
            o_result_vld <= i_req;       // pulses even with nothing to send
            if (i_req) begin
                o_result <= pick;
            end
        end
    end

endmodule

// ==== design/sched_pkg.sv ====
package sched_pkg;

    localparam int NUM_QUEUES = 8;   // priority queues per egress port
    localparam int GCL_DEPTH  = 8;   // max gate control list entries

    typedef logic [NUM_QUEUES-1:0] queue_mask_t;  // one bit per queue
    typedef logic [7:0]            slope_t;       // credit step per clock
    typedef logic signed [15:0]    credit_t;      // credit and thresholds
    typedef logic [15:0]           interval_t;    // gate entry length, cycles
    typedef logic [2:0]            gcl_idx_t;     // gate list entry index

    // apb side
    typedef logic [7:0]            apb_addr_t;
    typedef logic [15:0]           apb_data_t;

    // register map, queue and entry banks are 8 words each
    localparam apb_addr_t ADDR_CTRL       = 8'h00;
    localparam apb_addr_t ADDR_IDLE_BASE  = 8'h10;  // idle slope per queue
    localparam apb_addr_t ADDR_SEND_BASE  = 8'h18;  // send slope per queue
    localparam apb_addr_t ADDR_HI_BASE    = 8'h20;  // high credit limit
    localparam apb_addr_t ADDR_LO_BASE    = 8'h28;  // low credit limit
    localparam apb_addr_t ADDR_GMASK_BASE = 8'h30;  // gate mask per entry
    localparam apb_addr_t ADDR_GIVL_BASE  = 8'h38;  // gate interval per entry

    // ctrl register fields
    localparam int CTRL_QAV_BIT = 0;
    localparam int CTRL_QBV_BIT = 1;
    localparam int CTRL_LEN_LSB = 4;  // list length minus one

endpackage

// ==== design/sched_regs.sv ====
`timescale 1ns/10ps

module sched_regs #(
    parameter int NUM_QUEUES = sched_pkg::NUM_QUEUES
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // apb slave
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  sched_pkg::apb_addr_t   i_paddr,
    input  sched_pkg::apb_data_t   i_pwdata,
    output sched_pkg::apb_data_t   o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    // qav config
    output logic                   o_qav_en,
    output sched_pkg::slope_t      o_idle_slope [NUM_QUEUES],
    output sched_pkg::slope_t      o_send_slope [NUM_QUEUES],
    output sched_pkg::credit_t     o_hi_thresh [NUM_QUEUES],
    output sched_pkg::credit_t     o_lo_thresh [NUM_QUEUES],
    // qbv config
    output logic                   o_qbv_en,
    output sched_pkg::queue_mask_t o_gate_mask [sched_pkg::GCL_DEPTH],
    output sched_pkg::interval_t   o_gate_interval [sched_pkg::GCL_DEPTH],
    output sched_pkg::gcl_idx_t    o_list_last
);

    logic       sel_ctrl, sel_idle, sel_send, sel_hi, sel_lo, sel_gmask, sel_givl;
    logic       hit;      // address lands in the map
    logic       wr_en;    // write, access phase
    logic [2:0] idx;      // word within a bank
    sched_pkg::apb_data_t rd_mux;

    // bank match on the upper address bits
    function automatic logic in_bank(sched_pkg::apb_addr_t a, sched_pkg::apb_addr_t base);
        return a[7:3] == base[7:3];
    endfunction

    assign idx = i_paddr[2:0];

    // decode, queue banks only as deep as the queue count
    assign sel_ctrl  = (i_paddr == sched_pkg::ADDR_CTRL);
    assign sel_idle  = in_bank(i_paddr, sched_pkg::ADDR_IDLE_BASE) && (int'(idx) < NUM_QUEUES);
    assign sel_send  = in_bank(i_paddr, sched_pkg::ADDR_SEND_BASE) && (int'(idx) < NUM_QUEUES);
    assign sel_hi    = in_bank(i_paddr, sched_pkg::ADDR_HI_BASE) && (int'(idx) < NUM_QUEUES);
    assign sel_lo    = in_bank(i_paddr, sched_pkg::ADDR_LO_BASE) && (int'(idx) < NUM_QUEUES);
    assign sel_gmask = in_bank(i_paddr, sched_pkg::ADDR_GMASK_BASE);
    assign sel_givl  = in_bank(i_paddr, sched_pkg::ADDR_GIVL_BASE);

    assign hit   = sel_ctrl | sel_idle | sel_send | sel_hi | sel_lo | sel_gmask | sel_givl;
    assign wr_en = i_psel & i_penable & i_pwrite & hit;  // unmapped writes dropped

    // read mux, narrow fields zero-extended
    always_comb begin
        rd_mux = '0;
        if (sel_ctrl) begin
            rd_mux[sched_pkg::CTRL_QAV_BIT] = o_qav_en;
            rd_mux[sched_pkg::CTRL_QBV_BIT] = o_qbv_en;
            rd_mux[sched_pkg::CTRL_LEN_LSB +: $bits(sched_pkg::gcl_idx_t)] = o_list_last;
        end else if (sel_idle) begin
            rd_mux = sched_pkg::apb_data_t'(o_idle_slope[idx]);
        end else if (sel_send) begin
            rd_mux = sched_pkg::apb_data_t'(o_send_slope[idx]);
        end else if (sel_hi) begin
            rd_mux = sched_pkg::apb_data_t'(o_hi_thresh[idx]);
        end else if (sel_lo) begin
            rd_mux = sched_pkg::apb_data_t'(o_lo_thresh[idx]);
        end else if (sel_gmask) begin
            rd_mux = sched_pkg::apb_data_t'(o_gate_mask[idx]);
        end else if (sel_givl) begin
            rd_mux = o_gate_interval[idx];
        end
    end

    assign o_prdata  = rd_mux;                         // zero on a miss
    assign o_pready  = 1'b1;                           // no wait states
    assign o_pslverr = i_psel & i_penable & ~hit;

    // register storage, update on the edge closing the access phase
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_qav_en    <= 1'b0;
            o_qbv_en    <= 1'b0;
            o_list_last <= '0;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                o_idle_slope[q] <= '0;
                o_send_slope[q] <= '0;
                o_hi_thresh[q]  <= '0;
                o_lo_thresh[q]  <= '0;
            end
            for (int e = 0; e < sched_pkg::GCL_DEPTH; e++) begin
                o_gate_mask[e]     <= '0;
                o_gate_interval[e] <= '0;
            end
        end else if (wr_en) begin
            if (sel_ctrl) begin
                o_qav_en    <= i_pwdata[sched_pkg::CTRL_QAV_BIT];
                o_qbv_en    <= i_pwdata[sched_pkg::CTRL_QBV_BIT];
                o_list_last <= i_pwdata[sched_pkg::CTRL_LEN_LSB +: $bits(sched_pkg::gcl_idx_t)];
            end else if (sel_idle) begin
                o_idle_slope[idx] <= i_pwdata[7:0];
            end else if (sel_send) begin
                o_send_slope[idx] <= i_pwdata[7:0];
            end else if (sel_hi) begin
                o_hi_thresh[idx] <= sched_pkg::credit_t'(i_pwdata);
            end else if (sel_lo) begin
                o_lo_thresh[idx] <= sched_pkg::credit_t'(i_pwdata);
            end else if (sel_gmask) begin
                o_gate_mask[idx] <= i_pwdata[sched_pkg::NUM_QUEUES-1:0];
            end else begin
                o_gate_interval[idx] <= i_pwdata;  // sel_givl
            end
        end
    end

endmodule

// ==== design/sched_top.sv ====
`timescale 1ns/10ps

module sched_top #(
    parameter int NUM_QUEUES = sched_pkg::NUM_QUEUES
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // apb config port
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  sched_pkg::apb_addr_t   i_paddr,
    input  sched_pkg::apb_data_t   i_pwdata,
    output sched_pkg::apb_data_t   o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    // crossbar and mac side
    input  sched_pkg::queue_mask_t i_fifo_empty,
    input  logic                   i_tx_req,
    input  logic                   i_tx_valid,
    input  logic                   i_tx_last,
    output sched_pkg::queue_mask_t o_sched_result,
    output logic                   o_sched_valid
);

    // config from the register file
    logic                   w_qav_en;
    logic                   w_qbv_en;
    sched_pkg::slope_t      w_idle_slope [NUM_QUEUES];
    sched_pkg::slope_t      w_send_slope [NUM_QUEUES];
    sched_pkg::credit_t     w_hi_thresh [NUM_QUEUES];
    sched_pkg::credit_t     w_lo_thresh [NUM_QUEUES];
    sched_pkg::queue_mask_t w_gate_mask [sched_pkg::GCL_DEPTH];
    sched_pkg::interval_t   w_gate_interval [sched_pkg::GCL_DEPTH];
    sched_pkg::gcl_idx_t    w_list_last;

    // scheduling masks
    sched_pkg::queue_mask_t w_eligible;
    sched_pkg::queue_mask_t w_gate_open;

    sched_regs #(
        .NUM_QUEUES      (NUM_QUEUES)
    ) u_regs (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_psel          (i_psel),
        .i_penable       (i_penable),
        .i_pwrite        (i_pwrite),
        .i_paddr         (i_paddr),
        .i_pwdata        (i_pwdata),
        .o_prdata        (o_prdata),
        .o_pready        (o_pready),
        .o_pslverr       (o_pslverr),
        .o_qav_en        (w_qav_en),
        .o_idle_slope    (w_idle_slope),
        .o_send_slope    (w_send_slope),
        .o_hi_thresh     (w_hi_thresh),
        .o_lo_thresh     (w_lo_thresh),
        .o_qbv_en        (w_qbv_en),
        .o_gate_mask     (w_gate_mask),
        .o_gate_interval (w_gate_interval),
        .o_list_last     (w_list_last)
    );

    credit_shaper #(
        .NUM_QUEUES   (NUM_QUEUES)
    ) u_shaper (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_qav_en     (w_qav_en),
        .i_idle_slope (w_idle_slope),
        .i_send_slope (w_send_slope),
        .i_hi_thresh  (w_hi_thresh),
        .i_lo_thresh  (w_lo_thresh),
        .i_fifo_empty (i_fifo_empty),
        .i_tx_queue   (o_sched_result),   // held decision names the sender
        .i_tx_valid   (i_tx_valid),
        .i_tx_last    (i_tx_last),
        .o_eligible   (w_eligible)
    );

    gate_ctrl #(
        .NUM_QUEUES      (NUM_QUEUES)
    ) u_gate (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_qbv_en        (w_qbv_en),
        .i_gate_mask     (w_gate_mask),
        .i_gate_interval (w_gate_interval),
        .i_list_last     (w_list_last),
        .o_gate_open     (w_gate_open)
    );

    prio_select #(
        .NUM_QUEUES   (NUM_QUEUES)
    ) u_select (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_tx_req),
        .i_fifo_empty (i_fifo_empty),
        .i_gate_open  (w_gate_open),
        .i_eligible   (w_eligible),
        .o_result     (o_sched_result),
        .o_result_vld (o_sched_valid)
    );

endmodule

// ==== test/sched_props.sv ====
`timescale 1ns/10ps

module sched_props (
    input logic                   i_clk,
    input logic                   i_rst_n,
    input logic                   i_tx_req,
    input logic                   i_sched_valid,
    input sched_pkg::queue_mask_t i_sched_result,
    input logic                   i_pready
);

    // decision one cycle after each request
    valid_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tx_req |=> i_sched_valid)
        else $error("scheduler valid missing one cycle after a request");

    // and never without one
    valid_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sched_valid |-> $past(i_tx_req))
        else $error("scheduler valid without a request the cycle before");

    result_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_sched_result))
        else $error("scheduler result has more than one queue set");

    ready_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pready)
        else $error("apb pready dropped");

endmodule

bind sched_top sched_props u_props (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_tx_req       (i_tx_req),
    .i_sched_valid  (o_sched_valid),
    .i_sched_result (o_sched_result),
    .i_pready       (o_pready)
);

// ==== test/sched_tb.sv ====
`timescale 1ns/10ps

module sched_tb;

    localparam int NUM_QUEUES = sched_pkg::NUM_QUEUES;
    localparam int CLK_PERIOD = 20;
    localparam int FRAME_LEN  = 10;   // beats per shaped frame
    localparam int IDLE_SLOPE = 1;    // queue 7 credit gain per cycle
    localparam int SEND_SLOPE = 50;   // queue 7 credit loss per beat
    // cycle budget summed over reset, regs, 3 clears and the remaining tests
    localparam int RUN_CYCLES  = 10 + 220 + 3 * 100 + 90 + 150 + 540 + 30;
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n;
    logic                   psel, penable, pwrite;
    sched_pkg::apb_addr_t   paddr;
    sched_pkg::apb_data_t   pwdata;
    sched_pkg::apb_data_t   prdata;
    logic                   pready, pslverr;
    sched_pkg::queue_mask_t fifo_empty;
    logic                   tx_req, tx_valid, tx_last;
    sched_pkg::queue_mask_t sched_result;
    logic                   sched_valid;

    sched_top #(
        .NUM_QUEUES     (NUM_QUEUES)
    ) UUT (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr),
        .i_fifo_empty   (fifo_empty),
        .i_tx_req       (tx_req),
        .i_tx_valid     (tx_valid),
        .i_tx_last      (tx_last),
        .o_sched_result (sched_result),
        .o_sched_valid  (sched_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input sched_pkg::apb_data_t expected,
                         input sched_pkg::apb_data_t actual);
        if (expected !== actual) begin
            stop_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // every task starts and ends 2 ns past a rising edge
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic apb_write(input sched_pkg::apb_addr_t addr, input sched_pkg::apb_data_t data);
        psel    = 1'b1;   // setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        idle(1);
        penable = 1'b1;   // access phase without wait states
        idle(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input sched_pkg::apb_addr_t addr, output sched_pkg::apb_data_t data,
                            output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        idle(1);
        penable = 1'b1;
        #5;               // mid access phase
        data = prdata;
        err  = pslverr;
        check("apb_ready", 16'd1, 16'(pready));
        idle(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // pulse the request and sample the decision a cycle later
    task automatic request(input string name, output sched_pkg::queue_mask_t res);
        tx_req = 1'b1;
        idle(1);
        tx_req = 1'b0;
        check(name, 16'd1, 16'(sched_valid));
        res = sched_result;
    endtask

    task automatic send_frame(input int n);
        for (int i = 0; i < n; i++) begin
            tx_valid = 1'b1;
            tx_last  = (i == n - 1);
            idle(1);
        end
        tx_valid = 1'b0;
        tx_last  = 1'b0;
    endtask

    // top non-empty queue wins or zero when all empty
    function automatic sched_pkg::queue_mask_t expected_pick(sched_pkg::queue_mask_t empty);
        sched_pkg::queue_mask_t pick;
        pick = '0;
        for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
            if (!empty[q] && pick == '0) begin
                pick[q] = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic sched_pkg::apb_addr_t bank_base(input int k);
        case (k)
            0:       return sched_pkg::ADDR_IDLE_BASE;
            1:       return sched_pkg::ADDR_SEND_BASE;
            2:       return sched_pkg::ADDR_HI_BASE;
            3:       return sched_pkg::ADDR_LO_BASE;
            4:       return sched_pkg::ADDR_GMASK_BASE;
            default: return sched_pkg::ADDR_GIVL_BASE;
        endcase
    endfunction

    // slopes are 8 bit and gate masks one bit per queue
    function automatic sched_pkg::apb_data_t bank_mask(input int k);
        if (k == 0 || k == 1) return 16'h00FF;
        if (k == 4) return 16'((1 << NUM_QUEUES) - 1);
        return 16'hFFFF;
    endfunction

    function automatic sched_pkg::apb_data_t fill_pattern(input sched_pkg::apb_addr_t a);
        return {~a, a ^ 8'h5A};
    endfunction

    task automatic clear_regs();
        sched_pkg::apb_addr_t a;
        apb_write(sched_pkg::ADDR_CTRL, 16'h0000);   // shaper and gates off first
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 8; i++) begin
                a = bank_base(k) + 3'(i);
                apb_write(a, 16'h0000);
            end
        end
    endtask

    task automatic reg_access();
        sched_pkg::apb_data_t rd;
        sched_pkg::apb_addr_t a;
        logic                 err;
        check("reg_reset_valid", 16'd0, 16'(sched_valid));
        check("reg_reset_result", 16'd0, 16'(sched_result));
        apb_read(sched_pkg::ADDR_CTRL, rd, err);
        check("reg_reset_ctrl", 16'h0000, rd);
        apb_write(sched_pkg::ADDR_CTRL, 16'hFF73);   // enables and list length stick
        apb_read(sched_pkg::ADDR_CTRL, rd, err);
        check("reg_ctrl", 16'h0073, rd);
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 8; i++) begin
                a = bank_base(k) + 3'(i);
                apb_write(a, fill_pattern(a));
            end
        end
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 8; i++) begin
                a = bank_base(k) + 3'(i);
                apb_read(a, rd, err);
                check("reg_bank", fill_pattern(a) & bank_mask(k), rd);
                check("reg_bank_err", 16'd0, 16'(err));
            end
        end
        apb_write(8'h04, 16'hFFFF);                  // hole in the map so the write is dropped
        apb_read(8'h04, rd, err);
        check("reg_unmapped_data", 16'h0000, rd);
        check("reg_unmapped_err", 16'd1, 16'(err));
        apb_read(8'h40, rd, err);
        check("reg_unmapped_data", 16'h0000, rd);
        check("reg_unmapped_err", 16'd1, 16'(err));
        apb_read(sched_pkg::ADDR_CTRL, rd, err);
        check("reg_ctrl_kept", 16'h0073, rd);
    endtask

    task automatic strict_priority();
        sched_pkg::queue_mask_t res, pattern;
        clear_regs();
        for (int n = 0; n < 40; n++) begin
            pattern = (n == 0) ? '1 : sched_pkg::queue_mask_t'($urandom);
            fifo_empty = pattern;
            request("strict_prio", res);
            check("strict_prio", 16'(expected_pick(pattern)), 16'(res));
            idle(1);
            check("strict_prio_pulse", 16'd0, 16'(sched_valid));   // one cycle only
        end
    endtask

    task automatic gate_list();
        sched_pkg::queue_mask_t res, last;
        sched_pkg::queue_mask_t seen[$];
        clear_regs();
        fifo_empty = '0;
        apb_write(sched_pkg::ADDR_GMASK_BASE, 16'h000F);          // queues 0..3
        apb_write(sched_pkg::ADDR_CTRL, 16'h0002);
        idle(1);                                                  // entry 0 live a cycle later
        for (int n = 0; n < 6; n++) begin
            request("gate_single", res);
            check("gate_single", 16'h0008, 16'(res));
        end
        apb_write(sched_pkg::ADDR_CTRL, 16'h0000);
        apb_write(sched_pkg::ADDR_GMASK_BASE + 8'd1, 16'h0030);   // queues 4, 5
        apb_write(sched_pkg::ADDR_GIVL_BASE, 16'd40);
        apb_write(sched_pkg::ADDR_GIVL_BASE + 8'd1, 16'd40);
        apb_write(sched_pkg::ADDR_CTRL, 16'h0012);                // two entries
        idle(1);
        last = '0;
        for (int n = 0; n < 100; n++) begin                       // 40 + 40 + 20 cycles
            request("gate_pair", res);
            if (res != last) seen.push_back(res);
            last = res;
        end
        check("gate_pair_changes", 16'd3, 16'(seen.size()));
        check("gate_pair_entry0", 16'h0008, 16'(seen[0]));
        check("gate_pair_entry1", 16'h0020, 16'(seen[1]));
        check("gate_pair_wrap", 16'h0008, 16'(seen[2]));
        apb_write(sched_pkg::ADDR_CTRL, 16'h0000);
        idle(1);
        request("gate_off", res);
        check("gate_off", 16'h0080, 16'(res));
    endtask

    task automatic shaper_blocking();
        sched_pkg::queue_mask_t res;
        int                     k;
        clear_regs();                                           // hi limits 0 so q6 stays at 0
        fifo_empty = '0;
        apb_write(sched_pkg::ADDR_IDLE_BASE + 8'd7, 16'(IDLE_SLOPE));
        apb_write(sched_pkg::ADDR_SEND_BASE + 8'd7, 16'(SEND_SLOPE));
        apb_write(sched_pkg::ADDR_LO_BASE + 8'd7, 16'hFC18);    // -1000
        apb_write(sched_pkg::ADDR_CTRL, 16'h0001);
        request("shaper_first", res);
        check("shaper_first", 16'h0080, 16'(res));
        send_frame(FRAME_LEN);                                  // credit ends at -500
        request("shaper_block", res);
        check("shaper_block", 16'h0040, 16'(res));
        k = 1;
        while (res != 8'h80) begin
            k++;
            if (k > 700) stop_run("queue 7 never became eligible again after its frame");
            request("shaper_recover", res);
        end
        // decision k sees -500 + (k-1) gains and first reaches zero at k = 501
        check("shaper_recover", 16'(FRAME_LEN * SEND_SLOPE / IDLE_SLOPE + 1), 16'(k));
    endtask

    task automatic shaper_disable();
        sched_pkg::queue_mask_t res;
        send_frame(FRAME_LEN);                                  // held result is queue 7
        request("shaper_disable", res);
        check("shaper_disable_blocked", 16'h0040, 16'(res));
        apb_write(sched_pkg::ADDR_CTRL, 16'h0000);
        request("shaper_disable", res);
        check("shaper_disable", 16'h0080, 16'(res));
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_run("timeout, the tests did not finish within the expected run time");
    end

    initial begin
        void'($urandom(87135));
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        fifo_empty = '1;
        tx_req     = 1'b0;
        tx_valid   = 1'b0;
        tx_last    = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reg_access();
        strict_priority();
        gate_list();
        shaper_blocking();
        shaper_disable();
        $display("sim passed");
        $finish;
    end

endmodule
